// File: rtl/tick_timer_pkg.sv
// Tick timer package with channel count, widths and load-word layout
package tick_timer_pkg;

    // Number of independent timer channels
    localparam int num_timers = 4;

    // Period and counter width
    localparam int period_w = 16;

    // Channel index width, enough to name every channel
    localparam int chan_w = 2;

    // Target word layout
    //   [load_w-1:period_w]  channel index
    //   [period_w-1:0]       period in clk_fast cycles
    localparam int load_w = chan_w + period_w;

    // Period or running count
    typedef logic [period_w-1:0] period_t;

    // Channel number as carried on the event stream
    typedef logic [chan_w-1:0] chan_t;

endpackage

// File: rtl/target_loader.sv
// Target loader that turns stream words into a per-channel load strobe and period
`timescale 1ns/1ps

module target_loader (
    input  logic                                clk_fast,
    input  logic                                reset_n,
    input  logic [tick_timer_pkg::load_w-1:0]   s_axis_tdata,
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,
    output logic [tick_timer_pkg::num_timers-1:0] load,
    output tick_timer_pkg::period_t             period
);
    import tick_timer_pkg::*;

    logic [chan_w-1:0]     index;
    logic [num_timers-1:0] load_d;

    // Every channel can take a new period on any cycle
    assign s_axis_tready = 1'b1;

    assign index = s_axis_tdata[load_w-1:period_w];

    // One-hot decode of the channel index
    always_comb begin
        load_d = '0;
        if (s_axis_tvalid) begin
            load_d[index] = 1'b1;
        end
    end

    // Load strobe, one cycle after the accepted word
    always_ff @(posedge clk_fast or negedge reset_n) begin
        if (!reset_n) begin
            load <= '0;
        end else begin
            load <= load_d;
        end
    end

    // Period bus travels alongside the strobe
    always_ff @(posedge clk_fast) begin
        if (s_axis_tvalid) begin
            period <= s_axis_tdata[period_w-1:0];
        end
    end

endmodule

// File: rtl/interval_counter.sv
// Interval counter that wraps at its loaded period and flips a tick toggle
`timescale 1ns/1ps

module interval_counter (
    input  logic                    clk_fast,
    input  logic                    reset_n,
    input  logic                    load,
    input  tick_timer_pkg::period_t period,
    output logic                    tick_toggle
);
    import tick_timer_pkg::*;

    period_t period_q;
    period_t count_q;
    logic    running;
    logic    wrap;

    // Zero period means the channel is stopped
    assign running = (period_q != '0);

    // Count runs 0 .. P-1
    assign wrap = running && (count_q == period_q - period_t'(1));

    always_ff @(posedge clk_fast or negedge reset_n) begin
        if (!reset_n) begin
            period_q <= '0;
        end else if (load) begin
            period_q <= period;
        end
    end

    always_ff @(posedge clk_fast or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (load) begin
            // Restart so the first tick lands P cycles after the load
            count_q <= '0;
        end else if (wrap) begin
            count_q <= '0;
        end else if (running) begin
            count_q <= count_q + period_t'(1);
        end
    end

    // One flip per wrap; the slow side sees edges, not levels
    always_ff @(posedge clk_fast or negedge reset_n) begin
        if (!reset_n) begin
            tick_toggle <= 1'b0;
        end else if (!load && wrap) begin
            tick_toggle <= ~tick_toggle;
        end
    end

endmodule

// File: rtl/tick_sync.sv
// Tick synchronizer that brings a fast-domain toggle into clk_slow as a pending flag
`timescale 1ns/1ps

module tick_sync (
    input  logic clk_slow,
    input  logic reset_n,
    input  logic tick_toggle,
    input  logic grant,
    output logic pending
);

    logic [1:0] sync_q;
    logic       edge_q;
    logic       tick;

    // Two-flop synchronizer on the crossing toggle
    always_ff @(posedge clk_slow or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], tick_toggle};
        end
    end

    // Previous synchronized value for edge detection
    always_ff @(posedge clk_slow or negedge reset_n) begin
        if (!reset_n) begin
            edge_q <= 1'b0;
        end else begin
            edge_q <= sync_q[1];
        end
    end

    // Either toggle direction is one tick
    assign tick = sync_q[1] ^ edge_q;

    // Set wins over grant, so a tick arriving with the grant is kept.
    // Ticks landing while already pending merge into the one flag.
    always_ff @(posedge clk_slow or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
        end else if (tick) begin
            pending <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

endmodule

// File: rtl/timer_channel.sv
// Timer channel joining a fast-domain counter with its slow-domain tick synchronizer
`timescale 1ns/1ps

module timer_channel (
    input  logic                    clk_fast,
    input  logic                    clk_slow,
    input  logic                    reset_n,
    input  logic                    load,
    input  tick_timer_pkg::period_t period,
    input  logic                    grant,
    output logic                    pending
);

    // The only signal crossing from clk_fast to clk_slow
    logic tick_toggle;

    // Fast side
    interval_counter u_counter (
        .clk_fast    (clk_fast),
        .reset_n     (reset_n),
        .load        (load),
        .period      (period),
        .tick_toggle (tick_toggle)
    );

    // Slow side
    tick_sync u_sync (
        .clk_slow    (clk_slow),
        .reset_n     (reset_n),
        .tick_toggle (tick_toggle),
        .grant       (grant),
        .pending     (pending)
    );

endmodule

// File: rtl/tick_arbiter.sv
// Round-robin arbiter that picks a pending channel and drives the event stream
`timescale 1ns/1ps

module tick_arbiter (
    input  logic                                  clk_slow,
    input  logic                                  reset_n,
    input  logic [tick_timer_pkg::num_timers-1:0] pending,
    output logic [tick_timer_pkg::num_timers-1:0] grant,
    output tick_timer_pkg::chan_t                 m_axis_tdata,
    output logic                                  m_axis_tvalid,
    output logic                                  m_axis_tlast,
    input  logic                                  m_axis_tready
);
    import tick_timer_pkg::*;

    chan_t last_q;
    chan_t winner;
    logic  found;
    logic  take;

    // Output slot is empty or drains this cycle
    assign take = !m_axis_tvalid || m_axis_tready;

    // Search starts just after the last winner
    always_comb begin
        int idx;
        found  = 1'b0;
        winner = last_q;
        for (int i = 1; i <= num_timers; i++) begin
            idx = (int'(last_q) + i) % num_timers;
            if (!found && pending[idx]) begin
                found  = 1'b1;
                winner = chan_t'(idx);
            end
        end
    end

    // Grant clears the winner's pending flag on the loading edge
    always_comb begin
        grant = '0;
        if (take && found) begin
            grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge clk_slow or negedge reset_n) begin
        if (!reset_n) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            last_q        <= chan_t'(num_timers - 1);
        end else if (take) begin
            // Every event is a one-beat packet
            m_axis_tvalid <= found;
            m_axis_tlast  <= found;
            if (found) begin
                last_q <= winner;
            end
        end
    end

    // Channel number held under back-pressure
    always_ff @(posedge clk_slow) begin
        if (take && found) begin
            m_axis_tdata <= winner;
        end
    end

endmodule

// File: rtl/tick_timer_top.sv
// Four-channel interval timer with a fast load stream and a slow event stream
`timescale 1ns/1ps

module tick_timer_top (
    input  logic                                clk_fast,
    input  logic                                clk_slow,
    input  logic                                reset_n,

    // Target stream, clk_fast domain
    input  logic [tick_timer_pkg::load_w-1:0]   s_axis_tdata,
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,

    // Tick event stream, clk_slow domain
    output tick_timer_pkg::chan_t               m_axis_tdata,
    output logic                                m_axis_tvalid,
    input  logic                                m_axis_tready,
    output logic                                m_axis_tlast
);
    import tick_timer_pkg::*;

    logic [num_timers-1:0] load;
    period_t               period;
    logic [num_timers-1:0] pending;
    logic [num_timers-1:0] grant;

    target_loader u_loader (
        .clk_fast      (clk_fast),
        .reset_n       (reset_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .load          (load),
        .period        (period)
    );

    // One channel per timer, all sharing the period bus
    for (genvar c = 0; c < num_timers; c++) begin : g_chan
        timer_channel u_chan (
            .clk_fast (clk_fast),
            .clk_slow (clk_slow),
            .reset_n  (reset_n),
            .load     (load[c]),
            .period   (period),
            .grant    (grant[c]),
            .pending  (pending[c])
        );
    end

    tick_arbiter u_arbiter (
        .clk_slow      (clk_slow),
        .reset_n       (reset_n),
        .pending       (pending),
        .grant         (grant),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// File: test/tb_tick_timer.sv
// Testbench for the four-channel interval timer with load, rate, stop and back-pressure checks
`timescale 1ns/1ps

module tb_tick_timer;
    import tick_timer_pkg::*;

    // Testbench-only timing and stimulus constants
    localparam int fast_half = 5;
    localparam int slow_half = 20;
    localparam int idle_cycles = 200;
    localparam int stage_cycles = 300;
    localparam int settle_cycles = 2000;
    localparam int rate_window = 8000;
    localparam int stop_window = 2000;
    localparam int hold_cycles = 500;
    localparam int random_cycles = 3000;
    localparam logic [15:0] lfsr_seed = 16'd38257;

    // Back-pressure modes for m_axis_tready
    localparam int ready_high = 0;
    localparam int ready_low = 1;
    localparam int ready_random = 2;

    logic                  clk_fast;
    logic                  clk_slow;
    logic                  reset_n;
    logic [load_w-1:0]     s_axis_tdata;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    chan_t                 m_axis_tdata;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;
    logic                  m_axis_tlast;

    logic [15:0]           lfsr_state = lfsr_seed;
    int                    ready_mode = ready_high;
    logic [num_timers-1:0] loaded;
    logic                  ch2_silent;
    int                    event_count [num_timers];
    chan_t                 event_log [$];

    tick_timer_top u_dut (
        .clk_fast      (clk_fast),
        .clk_slow      (clk_slow),
        .reset_n       (reset_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

    initial begin
        clk_fast = 1'b0;
        forever #fast_half clk_fast = ~clk_fast;
    end

    initial begin
        clk_slow = 1'b0;
        forever #slow_half clk_slow = ~clk_slow;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(next_random_bit());
        end
        return value;
    endfunction

    task automatic load_period(input int chan, input int value);
        @(posedge clk_fast);
        #1;
        s_axis_tdata = {chan_t'(chan), period_t'(value)};
        s_axis_tvalid = 1'b1;
        if (value != 0) begin
            loaded[chan] = 1'b1;
        end
        @(posedge clk_fast);
        #1;
        s_axis_tvalid = 1'b0;
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk_fast);
        ready_mode = mode;
    endtask

    task automatic wait_for_events(input int target, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (event_log.size() < target) begin
            if (cycles >= limit) begin
                report_timeout(what);
            end
            @(negedge clk_fast);
            cycles++;
        end
    endtask

    task automatic wait_for_channel(input int chan, input int base, input int limit);
        int cycles;
        cycles = 0;
        while (event_count[chan] <= base) begin
            if (cycles >= limit) begin
                report_timeout($sformatf("no event arrived from channel %0d", chan));
            end
            @(negedge clk_fast);
            cycles++;
        end
    endtask

    task automatic wait_for_valid(input int limit);
        int cycles;
        cycles = 0;
        while (!m_axis_tvalid) begin
            if (cycles >= limit) begin
                report_timeout("m_axis_tvalid never rose while the sink was stalled");
            end
            @(negedge clk_fast);
            cycles++;
        end
    endtask

    // Sink back-pressure, driven just after each clk_slow edge
    always @(posedge clk_slow) begin
        #1;
        case (ready_mode)
            ready_low:    m_axis_tready = 1'b0;
            ready_random: m_axis_tready = next_random_bit();
            default:      m_axis_tready = 1'b1;
        endcase
    end

    // Event monitor, counts every transfer per channel
    always @(posedge clk_slow) begin
        if (reset_n && m_axis_tvalid && m_axis_tready) begin
            event_count[m_axis_tdata] = event_count[m_axis_tdata] + 1;
            event_log.push_back(m_axis_tdata);
        end
    end

    a_last_tracks_valid: assert property (@(posedge clk_slow) disable iff (!reset_n)
        m_axis_tlast == m_axis_tvalid)
        else report_mismatch("m_axis_tlast differs from m_axis_tvalid");

    a_hold_under_stall: assert property (@(posedge clk_slow) disable iff (!reset_n)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)))
        else report_mismatch("event changed or vanished while m_axis_tready was low");

    a_known_channel: assert property (@(posedge clk_slow) disable iff (!reset_n)
        (m_axis_tvalid && m_axis_tready) |-> loaded[m_axis_tdata])
        else report_mismatch("event names a channel that was never loaded");

    a_stopped_channel: assert property (@(posedge clk_slow) disable iff (!reset_n)
        (ch2_silent && m_axis_tvalid && m_axis_tready) |-> (m_axis_tdata != chan_t'(2)))
        else report_mismatch("stopped channel 2 still produced an event");

    initial begin
        int periods [num_timers];
        int snap [num_timers];
        int candidate;
        int unique_ok;
        int delta;
        int lo;
        int hi;
        int base;

        reset_n = 1'b0;
        s_axis_tdata = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        loaded = '0;
        ch2_silent = 1'b0;
        for (int c = 0; c < num_timers; c++) begin
            event_count[c] = 0;
        end
        repeat (2) @(posedge clk_fast);
        #1;
        reset_n = 1'b1;

        // Reset state, all channels stopped
        @(negedge clk_fast);
        assert (s_axis_tready) else report_mismatch("s_axis_tready low after reset");
        for (int i = 0; i < idle_cycles; i++) begin
            assert (!m_axis_tvalid) else report_mismatch("event while all channels stopped");
            @(negedge clk_fast);
        end

        // Distinct periods in 40..103, loaded one channel at a time
        // so that the higher channels stay unloaded while the lower ones tick
        for (int c = 0; c < num_timers; c++) begin
            unique_ok = 0;
            while (!unique_ok) begin
                candidate = 40 + random_bits(6);
                unique_ok = 1;
                for (int k = 0; k < c; k++) begin
                    if (periods[k] == candidate) begin
                        unique_ok = 0;
                    end
                end
            end
            periods[c] = candidate;
            load_period(c, candidate);
            repeat (stage_cycles) @(negedge clk_fast);
        end

        // Per-channel rate with the sink always ready
        set_ready_mode(ready_high);
        repeat (settle_cycles) @(negedge clk_fast);
        for (int c = 0; c < num_timers; c++) begin
            snap[c] = event_count[c];
        end
        repeat (rate_window) @(negedge clk_fast);
        for (int c = 0; c < num_timers; c++) begin
            delta = event_count[c] - snap[c];
            // Latency jitter can move one tick across each window edge
            lo = rate_window / periods[c] - 1;
            hi = (rate_window + periods[c] - 1) / periods[c] + 1;
            assert (delta >= lo && delta <= hi)
                else report_mismatch($sformatf("channel %0d gave %0d events, expected %0d..%0d",
                                               c, delta, lo, hi));
        end

        // Zero period stops channel 2
        load_period(2, 0);
        repeat (10) @(posedge clk_slow);
        ch2_silent = 1'b1;
        repeat (stop_window) @(negedge clk_fast);
        ch2_silent = 1'b0;

        // Fairness after a long stall
        load_period(2, periods[2]);
        set_ready_mode(ready_low);
        repeat (hold_cycles) @(negedge clk_fast);
        wait_for_valid(hold_cycles);
        base = event_log.size();
        set_ready_mode(ready_high);
        wait_for_events(base + num_timers, 200, "fewer than four events after the stall");
        for (int i = 0; i < num_timers; i++) begin
            for (int k = i + 1; k < num_timers; k++) begin
                assert (event_log[base + i] != event_log[base + k])
                    else report_mismatch($sformatf("channel %0d served twice after the stall",
                                                   event_log[base + i]));
            end
        end

        // Random back-pressure, every channel must still be heard
        for (int c = 0; c < num_timers; c++) begin
            snap[c] = event_count[c];
        end
        set_ready_mode(ready_random);
        repeat (random_cycles) @(negedge clk_fast);
        for (int c = 0; c < num_timers; c++) begin
            wait_for_channel(c, snap[c], 20 * periods[c] + 400);
        end
        set_ready_mode(ready_high);
        repeat (50) @(negedge clk_fast);

        $display("Test passed");
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        #2ms;
        report_timeout("the test did not finish within 2 ms");
    end

endmodule

// File: vlog.f
rtl/tick_timer_pkg.sv
rtl/target_loader.sv
rtl/interval_counter.sv
rtl/tick_sync.sv
rtl/timer_channel.sv
rtl/tick_arbiter.sv
rtl/tick_timer_top.sv
test/tb_tick_timer.sv

// File: Bender.yml
package:
  name: tick_timer

sources:
  - files:
      - rtl/tick_timer_pkg.sv
      - rtl/target_loader.sv
      - rtl/interval_counter.sv
      - rtl/tick_sync.sv
      - rtl/timer_channel.sv
      - rtl/tick_arbiter.sv
      - rtl/tick_timer_top.sv
  - target: test
    files:
      - test/tb_tick_timer.sv
